// File: vlog.f
rtl/rv_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/proc_control.sv
rtl/proc_top.sv
testbench/mem_model.sv
testbench/proc_tb.sv

// File: Bender.yml
package:
  name: rv32i_multicycle

sources:
  # core RTL in compile order
  - rtl/rv_pkg.sv
  - rtl/instr_decode.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/proc_control.sv
  - rtl/proc_top.sv
  # testbench
  - target: simulation
    files:
      - testbench/mem_model.sv
      - testbench/proc_tb.sv

// File: testbench/proc_tb.sv
// simulation top for the RV32I core that runs a table of short programs and checks out_data and halt
`timescale 1ns/1ns
`default_nettype none

module proc_tb
    import rv_pkg::*;
();

    localparam int max_rows     = 24;
    localparam int max_words    = 8;
    localparam int max_outs     = 4;
    localparam int run_limit    = 400;
    localparam int reset_cycles = 10;

    logic     clk;
    logic     rst;
    mem_req_t mem_req;
    word_t    mem_rd_data;
    logic     mem_ack;
    word_t    out_data;
    logic     out_valid;
    logic     halt;

    // program words, expected out words and halt flag per row
    word_t prog_tab [max_rows][max_words];
    int    prog_len [max_rows];
    word_t out_tab  [max_rows][max_outs];
    int    out_cnt  [max_rows];
    bit    halt_tab [max_rows];
    int    n_rows;

    int value_errors;
    int other_errors;
    bit timed_out;

    proc_top DUT (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    mem_model u_mem (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .rd_data (mem_rd_data),
        .ack     (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction encoders following the RV32I formats
    function automatic word_t r_type(input logic [9:0] f10, input reg_sel_t rd,
                                     input reg_sel_t rs1, input reg_sel_t rs2);
        return {f10[9:3], rs2, rs1, f10[2:0], rd, OP};
    endfunction

    function automatic word_t i_type(input opcode_t op, input logic [2:0] f3,
                                     input reg_sel_t rd, input reg_sel_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input reg_sel_t rs2, input reg_sel_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], STORE};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_sel_t rs1,
                                     input reg_sel_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic word_t u_type(input opcode_t op, input reg_sel_t rd,
                                     input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic word_t addi(input reg_sel_t rd, input reg_sel_t rs1,
                                   input logic [11:0] imm);
        return i_type(OPIMM, f3_addi, rd, rs1, imm);
    endfunction

    function automatic word_t out_store(input reg_sel_t rs2);
        return s_type(rs2, 5'd0, 12'd1000);
    endfunction

    function automatic word_t halt_store();
        return s_type(5'd0, 5'd0, 12'd1004);
    endfunction

    task automatic put_instr(input word_t w);
        prog_tab[n_rows][prog_len[n_rows]] = w;
        prog_len[n_rows]++;
    endtask

    task automatic put_out(input word_t w);
        out_tab[n_rows][out_cnt[n_rows]] = w;
        out_cnt[n_rows]++;
    endtask

    task automatic end_row(input bit ends_in_halt);
        halt_tab[n_rows] = ends_in_halt;
        n_rows++;
    endtask

    // x3 = x1 op_a x2 and x4 = x1 op_b x2 go to the output port
    task automatic alu_row(input word_t set1, input word_t set2, input logic [9:0] op_a,
                           input word_t exp_a, input logic [9:0] op_b, input word_t exp_b);
        put_instr(set1);
        put_instr(set2);
        put_instr(r_type(op_a, 5'd3, 5'd1, 5'd2));
        put_instr(out_store(5'd3));
        put_instr(r_type(op_b, 5'd4, 5'd1, 5'd2));
        put_instr(out_store(5'd4));
        put_instr(halt_store());
        put_out(exp_a);
        put_out(exp_b);
        end_row(1'b1);
    endtask

    // the taken branch skips an out of zero and the not-taken branch would skip to the halt
    task automatic branch_row(input logic [2:0] f3_taken, input logic [2:0] f3_not,
                              input bit swap, input word_t a, input word_t b);
        reg_sel_t left;
        reg_sel_t right;
        left  = swap ? 5'd2 : 5'd1;
        right = swap ? 5'd1 : 5'd2;
        put_instr(addi(5'd1, 5'd0, a[11:0]));
        put_instr(addi(5'd2, 5'd0, b[11:0]));
        put_instr(b_type(f3_taken, left, right, 13'd8));
        put_instr(out_store(5'd0));
        put_instr(out_store(5'd2));
        put_instr(b_type(f3_not, left, right, 13'd8));
        put_instr(out_store(5'd1));
        put_instr(halt_store());
        put_out(b);
        put_out(a);
        end_row(1'b1);
    endtask

    task automatic build_table();
        for (int r = 0; r < max_rows; r++) begin
            prog_len[r] = 0;
            out_cnt[r]  = 0;
        end
        n_rows = 0;
        alu_row(addi(5'd1, 5'd0, 12'hff8), addi(5'd2, 5'd0, 12'h003),
                f10_sra, 32'hffff_ffff, f10_slt, 32'h0000_0001);
        alu_row(addi(5'd1, 5'd0, 12'hff8), addi(5'd2, 5'd0, 12'h003),
                f10_sltu, 32'h0000_0000, f10_srl, 32'h1fff_ffff);
        alu_row(u_type(LUI, 5'd1, 20'h12345), addi(5'd2, 5'd0, 12'h007),
                f10_add, 32'h1234_5007, f10_sub, 32'h1234_4ff9);
        alu_row(addi(5'd1, 5'd0, 12'h5a5), addi(5'd2, 5'd0, 12'h3c3),
                f10_xor, 32'h0000_0666, f10_or, 32'h0000_07e7);
        // shift amount is the low 5 bits of 0x3c3
        alu_row(addi(5'd1, 5'd0, 12'h5a5), addi(5'd2, 5'd0, 12'h3c3),
                f10_and, 32'h0000_0181, f10_sll, 32'h0000_2d28);
        alu_row(u_type(LUI, 5'd1, 20'h12345), addi(5'd2, 5'd0, 12'hffd),
                f10_mul, 32'hc963_1000, f10_sltu, 32'h0000_0001);

        // sign-extended immediates and an auipc at address 0x14
        put_instr(addi(5'd1, 5'd0, 12'h800));
        put_instr(i_type(OPIMM, f3_xori, 5'd2, 5'd1, 12'hfff));
        put_instr(out_store(5'd2));
        put_instr(i_type(OPIMM, f3_andi, 5'd3, 5'd2, 12'h0f0));
        put_instr(out_store(5'd3));
        put_instr(u_type(AUIPC, 5'd4, 20'h00001));
        put_instr(out_store(5'd4));
        put_instr(halt_store());
        put_out(32'h0000_07ff);
        put_out(32'h0000_00f0);
        put_out(32'h0000_1014);
        end_row(1'b1);

        put_instr(u_type(LUI, 5'd1, 20'h80000));
        put_instr(i_type(OPIMM, f3_slti, 5'd2, 5'd1, 12'h001));
        put_instr(out_store(5'd2));
        put_instr(i_type(OPIMM, f3_sltiu, 5'd3, 5'd1, 12'h001));
        put_instr(out_store(5'd3));
        put_instr(i_type(OPIMM, f3_ori, 5'd4, 5'd1, 12'h0f0));
        put_instr(out_store(5'd4));
        put_instr(halt_store());
        put_out(32'h0000_0001);
        put_out(32'h0000_0000);
        put_out(32'h8000_00f0);
        end_row(1'b1);

        branch_row(f3_blt, f3_bltu, 1'b0, 32'hffff_ffff, 32'h0000_0001);
        branch_row(f3_bgeu, f3_bge, 1'b0, 32'hffff_ffff, 32'h0000_0001);
        branch_row(f3_beq, f3_bne, 1'b0, 32'h0000_0005, 32'h0000_0005);
        branch_row(f3_bne, f3_beq, 1'b0, 32'h0000_0005, 32'h0000_0006);
        branch_row(f3_bge, f3_blt, 1'b1, 32'hffff_ffff, 32'h0000_0001);
        branch_row(f3_bltu, f3_bgeu, 1'b1, 32'hffff_ffff, 32'h0000_0001);

        // store and load at 0x100 followed by a load into x0
        put_instr(u_type(LUI, 5'd1, 20'h12345));
        put_instr(addi(5'd1, 5'd1, 12'h678));
        put_instr(s_type(5'd1, 5'd0, 12'h100));
        put_instr(i_type(LOAD, f3_word, 5'd2, 5'd0, 12'h100));
        put_instr(out_store(5'd2));
        put_instr(i_type(LOAD, f3_word, 5'd0, 5'd0, 12'h100));
        put_instr(out_store(5'd0));
        put_instr(halt_store());
        put_out(32'h1234_5678);
        put_out(32'h0000_0000);
        end_row(1'b1);

        // base register with a negative offset
        put_instr(addi(5'd5, 5'd0, 12'h200));
        put_instr(addi(5'd6, 5'd0, 12'habc));
        put_instr(s_type(5'd6, 5'd5, 12'hffc));
        put_instr(i_type(LOAD, f3_word, 5'd7, 5'd5, 12'hffc));
        put_instr(out_store(5'd7));
        put_instr(halt_store());
        put_out(32'hffff_fabc);
        end_row(1'b1);

        // unknown opcode halts before the output store
        put_instr(addi(5'd1, 5'd0, 12'h005));
        put_instr(32'h0000_007f);
        put_instr(out_store(5'd1));
        put_instr(halt_store());
        end_row(1'b1);

        // sll with the alternate funct7 is not an instruction
        put_instr(r_type({f7_alt, f3_sll}, 5'd3, 5'd1, 5'd2));
        put_instr(out_store(5'd0));
        end_row(1'b1);

        // ends in a self loop and must never halt
        put_instr(addi(5'd1, 5'd0, 12'h009));
        put_instr(out_store(5'd1));
        put_instr(b_type(f3_beq, 5'd0, 5'd0, 13'd0));
        put_out(32'h0000_0009);
        end_row(1'b0);
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_idle_strobes(input logic exp_halt);
        compare_flag("out_valid", out_valid, 1'b0);
        compare_flag("halt", halt, exp_halt);
        compare_flag("mem_req.rd_req", mem_req.rd_req, 1'b0);
        compare_flag("mem_req.wr_req", mem_req.wr_req, 1'b0);
    endtask

    // memory is loaded while the core is held in reset
    task automatic apply_reset(input int r);
        @(negedge clk);
        rst = 1'b1;
        for (int c = 0; c < reset_cycles; c++) begin
            @(posedge clk);
            check_idle_strobes(1'b0);
            if (c == 0) begin
                u_mem.clear_memory();
                for (int k = 0; k < prog_len[r]; k++) begin
                    u_mem.load_word(k, prog_tab[r][k]);
                end
            end
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        compare_flag("mem_req.rd_req", mem_req.rd_req, 1'b1);
        compare_flag("mem_req.wr_req", mem_req.wr_req, 1'b0);
        compare_word("mem_req.addr", mem_req.addr, 32'h0000_0000);
    endtask

    task automatic run_row(input int r);
        int n_out;
        int cycles;
        bit saw_halt;
        n_out    = 0;
        cycles   = 0;
        saw_halt = 1'b0;
        while (!saw_halt && cycles < run_limit) begin
            @(posedge clk);
            cycles++;
            saw_halt = halt;
            if (out_valid) begin
                if (n_out < out_cnt[r]) begin
                    compare_word("out_data", out_data, out_tab[r][n_out]);
                end else begin
                    $display("row %0d: extra out word %h", r, out_data);
                    other_errors++;
                end
                n_out++;
            end
        end
        if (halt_tab[r] && !saw_halt) begin
            $display("row %0d: no halt within %0d cycles", r, run_limit);
            other_errors++;
            timed_out = 1'b1;
        end
        if (n_out != out_cnt[r]) begin
            $display("row %0d: %0d out words seen, %0d expected", r, n_out, out_cnt[r]);
            other_errors++;
        end
        compare_flag("halt", saw_halt, halt_tab[r]);
        if (saw_halt) begin
            // halt is a level and the bus stays quiet
            for (int c = 0; c < 8; c++) begin
                @(posedge clk);
                check_idle_strobes(1'b1);
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        build_table();
        for (int r = 0; r < n_rows && !timed_out; r++) begin
            apply_reset(r);
            run_row(r);
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/mem_model.sv
// word memory for the core testbench, answers each request after a random delay of 1 to 4 cycles
`timescale 1ns/1ns
`default_nettype none

module mem_model
    import rv_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire mem_req_t req,
    output word_t         rd_data,
    output logic          ack
);

    localparam int depth = 256;

    word_t    mem [depth];
    mem_req_t cur;
    logic     busy;
    int       wait_cycles;

    // every word gets a value that depends on its full index
    task automatic clear_memory();
        for (int k = 0; k < depth; k++) begin
            mem[k] = 32'hbad0_0000 | 32'(k);
        end
    endtask

    // program load, one word at a time
    task automatic load_word(input int idx, input word_t data);
        mem[idx] = data;
    endtask

    initial begin
        void'($urandom(15));
        rd_data     = '0;
        ack         = 1'b0;
        busy        = 1'b0;
        wait_cycles = 0;
        cur         = '0;
        forever begin
            // requests are sampled at the rising edge
            @(posedge clk);
            if (rst) begin
                busy = 1'b0;
            end else if (!busy && (req.rd_req || req.wr_req)) begin
                cur         = req;
                busy        = 1'b1;
                wait_cycles = 1 + int'($urandom % 32'd4);
            end
            // the answer goes out on the falling edge, never in the request cycle
            @(negedge clk);
            ack = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                wait_cycles--;
                if (wait_cycles == 0) begin
                    busy = 1'b0;
                    ack  = 1'b1;
                    if (cur.wr_req) begin
                        mem[cur.addr[9:2]] = cur.wr_data;
                    end else begin
                        rd_data = mem[cur.addr[9:2]];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/proc_top.sv
// top level of the RV32I core, connects decoder, register file, alu and sequencer to the memory
`timescale 1ns/1ns
`default_nettype none

module proc_top
    import rv_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    output mem_req_t   mem_req,
    input  wire word_t mem_rd_data,
    input  wire logic  mem_ack,
    output word_t      out_data,
    output logic       out_valid,
    output logic       halt
);

    instr_u   instr;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_b;
    word_t    alu_result;
    logic     taken;
    reg_wr_t  reg_wr;

    // second operand is the immediate for op-imm, load and store
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    instr_decode u_decode (
        .word (instr),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .wr       (reg_wr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .op     (dec.alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result),
        .taken  (taken)
    );

    proc_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .taken       (taken),
        .instr       (instr),
        .mem_req     (mem_req),
        .reg_wr      (reg_wr),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

endmodule

`default_nettype wire

// File: rtl/proc_control.sv
// sequencer of the multicycle core: fetch, data access, writeback, mapped output and halt
`timescale 1ns/1ns
`default_nettype none

module proc_control
    import rv_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire word_t    mem_rd_data,
    input  wire logic     mem_ack,
    input  wire decoded_t dec,
    input  wire word_t    rs1_data,
    input  wire word_t    rs2_data,
    input  wire word_t    alu_result,
    input  wire logic     taken,
    output instr_u        instr,
    output mem_req_t      mem_req,
    output reg_wr_t       reg_wr,
    output word_t         out_data,
    output logic          out_valid,
    output logic          halt
);

    // c0 first request, c1 fetch wait, c2 data wait
    typedef enum logic [1:0] {
        st_c0,
        st_c1,
        st_c2,
        st_halted
    } state_t;

    state_t   state;
    state_t   next_state;
    word_t    pc;
    word_t    next_pc;
    logic     pend_load;
    logic     next_pend_load;
    reg_sel_t pend_rd;
    reg_sel_t next_pend_rd;

    logic  fetch;
    word_t fetch_addr;
    word_t pc_plus4;
    word_t pc_rel;

    // the read data is only taken as an instruction in c1
    assign instr    = mem_rd_data;
    assign pc_plus4 = pc + 32'd4;
    assign pc_rel   = pc + dec.imm;
    assign halt     = state == st_halted;

    always_comb begin
        next_state     = state;
        next_pc        = pc;
        next_pend_load = pend_load;
        next_pend_rd   = pend_rd;
        mem_req        = '0;
        reg_wr         = '0;
        out_data       = '0;
        out_valid      = 1'b0;
        fetch          = 1'b0;
        fetch_addr     = pc_plus4;

        case (state)
            st_c0: begin
                // hold off the first fetch while reset is asserted
                if (!rst) begin
                    fetch      = 1'b1;
                    fetch_addr = pc;
                end
            end
            st_c1: begin
                if (mem_ack) begin
                    case (dec.op_class)
                        cls_alu: begin
                            reg_wr = '{en: 1'b1, sel: dec.rd, data: alu_result};
                            fetch  = 1'b1;
                        end
                        cls_lui: begin
                            reg_wr = '{en: 1'b1, sel: dec.rd, data: dec.imm};
                            fetch  = 1'b1;
                        end
                        cls_auipc: begin
                            reg_wr = '{en: 1'b1, sel: dec.rd, data: pc_rel};
                            fetch  = 1'b1;
                        end
                        cls_branch: begin
                            fetch = 1'b1;
                            if (taken) begin
                                fetch_addr = pc_rel;
                            end
                        end
                        cls_load: begin
                            mem_req.addr   = alu_result;
                            mem_req.rd_req = 1'b1;
                            next_pend_load = 1'b1;
                            next_pend_rd   = dec.rd;
                            next_state     = st_c2;
                        end
                        cls_store: begin
                            case (alu_result)
                                out_addr: begin
                                    // mapped output, nothing goes to memory
                                    out_data  = rs2_data;
                                    out_valid = 1'b1;
                                    fetch     = 1'b1;
                                end
                                halt_addr: next_state = st_halted;
                                default: begin
                                    mem_req.addr    = alu_result;
                                    mem_req.wr_data = rs2_data;
                                    mem_req.wr_req  = 1'b1;
                                    next_pend_load  = 1'b0;
                                    next_state      = st_c2;
                                end
                            endcase
                        end
                        default: next_state = st_halted;
                    endcase
                end
            end
            st_c2: begin
                if (mem_ack) begin
                    if (pend_load) begin
                        reg_wr = '{en: 1'b1, sel: pend_rd, data: mem_rd_data};
                    end
                    fetch = 1'b1;
                end
            end
            default: begin
                // halted, stays here until reset
            end
        endcase

        if (fetch) begin
            mem_req.addr   = fetch_addr;
            mem_req.rd_req = 1'b1;
            next_pc        = fetch_addr;
            next_state     = st_c1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_c0;
            pc        <= '0;
            pend_load <= 1'b0;
        end else begin
            state     <= next_state;
            pc        <= next_pc;
            pend_load <= next_pend_load;
        end
    end

    // destination of an outstanding load
    always_ff @(posedge clk) begin
        pend_rd <= next_pend_rd;
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
// integer alu of the core, gives the arithmetic result and the branch decision
`timescale 1ns/1ns
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        result,
    output logic         taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        result = '0;
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, lt_s};
            alu_sltu: result = {31'b0, lt_u};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            // low word of the product only
            alu_mul:  result = a * b;
            default:  result = '0;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        case (op)
            alu_beq:  taken = eq;
            alu_bne:  taken = !eq;
            alu_blt:  taken = lt_s;
            alu_bge:  taken = !lt_s;
            alu_bltu: taken = lt_u;
            alu_bgeu: taken = !lt_u;
            default:  taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
// integer register file of the core, two combinational read ports and one write port
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire reg_sel_t rs1,
    input  wire reg_sel_t rs2,
    input  wire reg_wr_t  wr,
    output word_t         rs1_data,
    output word_t         rs2_data
);

    // x0 has no storage
    word_t regs [1:num_regs-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 1; k < num_regs; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.en && wr.sel != '0) begin
            regs[wr.sel] <= wr.data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: rtl/instr_decode.sv
// instruction decoder, turns a fetched word into selects, immediate and op class for the core
`timescale 1ns/1ns
`default_nettype none

module instr_decode
    import rv_pkg::*;
(
    input  wire instr_u word,
    output decoded_t    dec
);

    always_comb begin
        // register selects sit at the same bits in every format
        dec.rd       = word.r.rd;
        dec.rs1      = word.r.rs1;
        dec.rs2      = word.r.rs2;
        dec.op_class = cls_illegal;
        dec.alu_op   = alu_add;
        dec.imm      = '0;
        dec.use_imm  = 1'b0;

        case (word.r.opcode)
            OPIMM: begin
                dec.op_class = cls_alu;
                dec.imm      = {{20{word.i.imm[11]}}, word.i.imm};
                dec.use_imm  = 1'b1;
                case (word.i.funct3)
                    f3_addi:  dec.alu_op = alu_add;
                    f3_slti:  dec.alu_op = alu_slt;
                    f3_sltiu: dec.alu_op = alu_sltu;
                    f3_xori:  dec.alu_op = alu_xor;
                    f3_ori:   dec.alu_op = alu_or;
                    f3_andi:  dec.alu_op = alu_and;
                    // shift immediates are not supported
                    default:  dec.op_class = cls_illegal;
                endcase
            end
            LOAD: begin
                // address comes out of the alu as rs1 + offset
                dec.imm     = {{20{word.i.imm[11]}}, word.i.imm};
                dec.use_imm = 1'b1;
                if (word.i.funct3 == f3_word) begin
                    dec.op_class = cls_load;
                end
            end
            STORE: begin
                dec.imm     = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
                dec.use_imm = 1'b1;
                if (word.s.funct3 == f3_word) begin
                    dec.op_class = cls_store;
                end
            end
            BRANCH: begin
                dec.op_class = cls_branch;
                dec.imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                           word.b.imm10_5, word.b.imm4_1, 1'b0};
                case (word.b.funct3)
                    f3_beq:  dec.alu_op = alu_beq;
                    f3_bne:  dec.alu_op = alu_bne;
                    f3_blt:  dec.alu_op = alu_blt;
                    f3_bge:  dec.alu_op = alu_bge;
                    f3_bltu: dec.alu_op = alu_bltu;
                    f3_bgeu: dec.alu_op = alu_bgeu;
                    default: dec.op_class = cls_illegal;
                endcase
            end
            OP: begin
                dec.op_class = cls_alu;
                case ({word.r.funct7, word.r.funct3})
                    f10_add:  dec.alu_op = alu_add;
                    f10_sub:  dec.alu_op = alu_sub;
                    f10_sll:  dec.alu_op = alu_sll;
                    f10_slt:  dec.alu_op = alu_slt;
                    f10_sltu: dec.alu_op = alu_sltu;
                    f10_xor:  dec.alu_op = alu_xor;
                    f10_srl:  dec.alu_op = alu_srl;
                    f10_sra:  dec.alu_op = alu_sra;
                    f10_or:   dec.alu_op = alu_or;
                    f10_and:  dec.alu_op = alu_and;
                    f10_mul:  dec.alu_op = alu_mul;
                    default:  dec.op_class = cls_illegal;
                endcase
            end
            LUI: begin
                dec.op_class = cls_lui;
                dec.imm      = {word.u.imm, 12'b0};
            end
            AUIPC: begin
                dec.op_class = cls_auipc;
                dec.imm      = {word.u.imm, 12'b0};
            end
            default: dec.op_class = cls_illegal;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
// shared widths, encodings and bus structs for the RV32I core; import into every RTL and test file
`default_nettype none

package rv_pkg;

    localparam int xlen          = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs      = 32;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    // immediate group
    localparam logic [2:0] f3_addi  = 3'b000;
    localparam logic [2:0] f3_slti  = 3'b010;
    localparam logic [2:0] f3_sltiu = 3'b011;
    localparam logic [2:0] f3_xori  = 3'b100;
    localparam logic [2:0] f3_ori   = 3'b110;
    localparam logic [2:0] f3_andi  = 3'b111;
    // only word accesses are supported
    localparam logic [2:0] f3_word  = 3'b010;

    // branch group
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // register group
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam logic [6:0] f7_mext = 7'b0000001;

    // {funct7, funct3} of the register group
    localparam logic [9:0] f10_add  = {f7_base, f3_add};
    localparam logic [9:0] f10_sub  = {f7_alt,  f3_add};
    localparam logic [9:0] f10_sll  = {f7_base, f3_sll};
    localparam logic [9:0] f10_slt  = {f7_base, f3_slt};
    localparam logic [9:0] f10_sltu = {f7_base, f3_sltu};
    localparam logic [9:0] f10_xor  = {f7_base, f3_xor};
    localparam logic [9:0] f10_srl  = {f7_base, f3_srl};
    localparam logic [9:0] f10_sra  = {f7_alt,  f3_srl};
    localparam logic [9:0] f10_or   = {f7_base, f3_or};
    localparam logic [9:0] f10_and  = {f7_base, f3_and};
    localparam logic [9:0] f10_mul  = {f7_mext, f3_add};

    // memory-mapped store targets
    localparam word_t out_addr  = 32'd1000;
    localparam word_t halt_addr = 32'd1004;

    typedef struct packed {
        logic [6:0] funct7;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        reg_sel_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_sel_t    rs1;
        logic [2:0]  funct3;
        reg_sel_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_sel_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    // one fetched word, viewed per instruction format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_mul,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_alu, cls_load, cls_store, cls_branch, cls_lui, cls_auipc, cls_illegal
    } op_class_t;

    typedef struct packed {
        op_class_t op_class;
        alu_op_t   alu_op;
        reg_sel_t  rd;
        reg_sel_t  rs1;
        reg_sel_t  rs2;
        word_t     imm;
        logic      use_imm;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wr_data;
        logic  rd_req;
        logic  wr_req;
    } mem_req_t;

    typedef struct packed {
        logic     en;
        reg_sel_t sel;
        word_t    data;
    } reg_wr_t;

endpackage

`default_nettype wire
